/* logic/cdromPkg.sv */
// --------------------
// CD-ROM shared types
// --------------------
`default_nettype none

package cdromPkg;

    // --------------------
    // Widths
    // --------------------
    localparam int BYTE_W       = 8;   // Host bus and byte FIFOs
    localparam int SAMPLE_W     = 16;  // PCM sample
    localparam int VOL_W        = 8;   // 0x80 is unity gain
    localparam int VOL_FRAC     = 7;   // 1.7 fixed point
    localparam int NUM_CHANNELS = 2;   // 0 left, 1 right

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef sample_t [NUM_CHANNELS-1:0] pcmFrame_t;  // Indexed by channel

    // Host address slots
    typedef enum logic [1:0] {
        ADDR_INDEX_STATUS = 2'd0,
        ADDR_CMD_RESP     = 2'd1,
        ADDR_PARAM        = 2'd2,
        ADDR_CTRL         = 2'd3
    } hostAddr_e;

    // One host access
    typedef struct packed {
        logic              cs;
        logic              write;
        hostAddr_e         adr;
        logic [BYTE_W-1:0] data;
    } hostBus_t;

    // Cross volumes, source channel first, output second
    typedef struct packed {
        logic [VOL_W-1:0] ll;
        logic [VOL_W-1:0] lr;
        logic [VOL_W-1:0] rl;
        logic [VOL_W-1:0] rr;
    } volumeSet_t;

endpackage

`default_nettype wire

/* logic/syncFifo.sv */
// --------------------
// Synchronous FWFT FIFO
// --------------------
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic             i_clk,
    input  logic             i_nrst,
    input  logic             i_clear,
    input  logic             i_wrEn,
    input  logic [WIDTH-1:0] i_wrData,
    input  logic             i_rdEn,
    output logic [WIDTH-1:0] o_rdData,
    output logic             o_notEmpty,
    output logic             o_full
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wrPtr;
    logic [DEPTH_LOG2-1:0] rdPtr;
    logic [DEPTH_LOG2:0]   count;      // One extra bit to tell full from empty
    logic                  push;
    logic                  pop;

    assign push = i_wrEn && !o_full;      // Drop on full
    assign pop  = i_rdEn && o_notEmpty;   // Ignore on empty

    assign o_notEmpty = (count != '0);
    assign o_full     = (count == (DEPTH_LOG2 + 1)'(DEPTH));
    assign o_rdData   = mem[rdPtr];       // Head shown without a read cycle

    // Storage array
    always_ff @(posedge i_clk) begin
        if (push) mem[wrPtr] <= i_wrData;
    end

    always_ff @(posedge i_clk) begin
        if (!i_nrst || i_clear) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= wrPtr + 1'b1;
            if (pop)  rdPtr <= rdPtr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/cdHostRegs.sv */
// --------------------
// CD-ROM host registers
// --------------------
`timescale 1ns/1ps
`default_nettype none

module cdHostRegs #(
    parameter int PARAM_DEPTH_LOG2 = 4,
    parameter int RESP_DEPTH_LOG2  = 4
) (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  cdromPkg::hostBus_t          i_host,
    output logic [cdromPkg::BYTE_W-1:0] o_hostData,
    output logic [cdromPkg::BYTE_W-1:0] o_paramData,
    output logic                        o_paramValid,
    input  logic                        i_paramTaken,
    input  logic [cdromPkg::BYTE_W-1:0] i_respData,
    input  logic                        i_respWrite,
    output cdromPkg::volumeSet_t        o_workVolumes
);

    import cdromPkg::*;

    logic [1:0]        index;
    logic [BYTE_W-1:0] intEnable;      // All 8 bits kept
    volumeSet_t        stagedVolumes;
    logic              wrAcc;
    logic              rdAcc;
    logic              paramPush;
    logic              paramClear;
    logic              paramFull;
    logic              applyVol;
    logic              respPop;
    logic [BYTE_W-1:0] respHead;
    logic              respNotEmpty;
    logic [BYTE_W-1:0] status;

    // --------------------
    // Access decode
    // --------------------
    assign wrAcc      = i_host.cs && i_host.write;
    assign rdAcc      = i_host.cs && !i_host.write;
    assign paramPush  = wrAcc && (i_host.adr == ADDR_PARAM) && (index == 2'd0);
    assign paramClear = wrAcc && (i_host.adr == ADDR_CTRL) && (index == 2'd1)
                        && i_host.data[6];
    assign applyVol   = wrAcc && (i_host.adr == ADDR_CTRL) && (index == 2'd3)
                        && i_host.data[5];
    assign respPop    = rdAcc && (i_host.adr == ADDR_CMD_RESP);  // FIFO guards empty

    syncFifo #(.WIDTH(BYTE_W), .DEPTH_LOG2(PARAM_DEPTH_LOG2)) paramFifo (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_clear    (paramClear),
        .i_wrEn     (paramPush),
        .i_wrData   (i_host.data),
        .i_rdEn     (i_paramTaken),
        .o_rdData   (o_paramData),
        .o_notEmpty (o_paramValid),
        .o_full     (paramFull)
    );

    // Response bytes from the drive side
    syncFifo #(.WIDTH(BYTE_W), .DEPTH_LOG2(RESP_DEPTH_LOG2)) respFifo (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_clear    (1'b0),
        .i_wrEn     (i_respWrite),
        .i_wrData   (i_respData),
        .i_rdEn     (respPop),
        .o_rdData   (respHead),
        .o_notEmpty (respNotEmpty),
        .o_full     ()
    );

    // --------------------
    // Register writes
    // --------------------
    always_ff @(posedge i_clk) begin
        if (!i_nrst) begin
            index         <= '0;
            intEnable     <= '0;
            stagedVolumes <= '0;
            o_workVolumes <= '0;
        end else begin
            if (wrAcc) begin
                case (i_host.adr)
                    ADDR_INDEX_STATUS: index <= i_host.data[1:0];
                    ADDR_CMD_RESP: begin
                        if (index == 2'd3) stagedVolumes.rr <= i_host.data;
                    end
                    ADDR_PARAM: begin
                        case (index)
                            2'd1:    intEnable        <= i_host.data;
                            2'd2:    stagedVolumes.ll <= i_host.data;
                            2'd3:    stagedVolumes.rl <= i_host.data;
                            default: ;                // Index 0 pushes to the FIFO
                        endcase
                    end
                    ADDR_CTRL: begin
                        if (index == 2'd2) stagedVolumes.lr <= i_host.data;
                    end
                endcase
            end
            if (applyVol) o_workVolumes <= stagedVolumes;  // Staged to working
        end
    end

    // Status byte with bits 7, 6 and 2 at zero
    assign status = {2'b00, respNotEmpty, !paramFull, !o_paramValid, 1'b0, index};

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        case (i_host.adr)
            ADDR_INDEX_STATUS: o_hostData = status;
            ADDR_CMD_RESP:     o_hostData = respNotEmpty ? respHead : '0;  // Empty reads 0
            ADDR_PARAM:        o_hostData = '0;
            ADDR_CTRL:         o_hostData = index[0] ? '0 : intEnable;
        endcase
    end

endmodule

`default_nettype wire

/* logic/cdSamplePacer.sv */
// --------------------
// Sample period tick
// --------------------
`timescale 1ns/1ps
`default_nettype none

module cdSamplePacer #(
    parameter int SAMPLE_PERIOD = 768
) (
    input  logic i_clk,
    input  logic i_nrst,
    output logic o_tick
);

    localparam int CNT_W = $clog2(SAMPLE_PERIOD);

    logic [CNT_W-1:0] count;
    logic             wrap;

    assign wrap = (count == CNT_W'(SAMPLE_PERIOD - 1));

    always_ff @(posedge i_clk) begin
        if (!i_nrst) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else begin
            count  <= wrap ? '0 : count + 1'b1;
            o_tick <= wrap;                      // Registered, first one after a full period
        end
    end

endmodule

`default_nettype wire

/* logic/cdPcmChannel.sv */
// --------------------
// PCM channel buffer
// --------------------
`timescale 1ns/1ps
`default_nettype none

module cdPcmChannel #(
    parameter int DEPTH_LOG2 = 13
) (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_tick,
    input  logic              i_write,
    input  cdromPkg::sample_t i_sample,
    output cdromPkg::sample_t o_sample,
    output logic              o_full
);

    import cdromPkg::*;

    logic [SAMPLE_W-1:0] head;
    logic                notEmpty;

    // One pop per tick, guarded on empty inside the FIFO
    syncFifo #(.WIDTH(SAMPLE_W), .DEPTH_LOG2(DEPTH_LOG2)) pcmFifo (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_clear    (1'b0),
        .i_wrEn     (i_write),       // Dropped silently when full
        .i_wrData   (i_sample),
        .i_rdEn     (i_tick),
        .o_rdData   (head),
        .o_notEmpty (notEmpty),
        .o_full     (o_full)
    );

    // Underflow plays silence
    assign o_sample = notEmpty ? sample_t'(head) : '0;

endmodule

`default_nettype wire

/* logic/cdVolumeMixer.sv */
// --------------------
// Cross-volume mixer
// --------------------
`timescale 1ns/1ps
`default_nettype none

module cdVolumeMixer (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    input  logic                 i_tick,
    input  cdromPkg::pcmFrame_t  i_samples,
    input  cdromPkg::volumeSet_t i_volumes,
    output cdromPkg::sample_t    o_mixL,
    output cdromPkg::sample_t    o_mixR,
    output logic                 o_sampleValid
);

    import cdromPkg::*;

    localparam int PROD_W  = VOL_W + 1 + SAMPLE_W;  // Volume gets a zero sign bit
    localparam int SCALE_W = PROD_W - VOL_FRAC;
    localparam int SUM_W   = SCALE_W + 1;           // Headroom for the add

    sample_t                   srcL;
    sample_t                   srcR;
    logic signed [SUM_W-1:0]   sumL;
    logic signed [SUM_W-1:0]   sumR;

    // Volume times sample, floor divided by 128
    function automatic logic signed [SCALE_W-1:0] scaleVol(
        input logic [VOL_W-1:0] vol,
        input sample_t          smp
    );
        logic signed [PROD_W-1:0] prod;
        prod = $signed({1'b0, vol}) * smp;
        return SCALE_W'(prod >>> VOL_FRAC);     // Arithmetic shift floors
    endfunction

    // Saturate to the 16-bit range
    function automatic sample_t clampSample(input logic signed [SUM_W-1:0] v);
        if (v > SUM_W'(32767))       return 16'sh7fff;
        else if (v < -SUM_W'(32768)) return 16'sh8000;
        else                         return sample_t'(v);
    endfunction

    assign srcL = i_samples[0];
    assign srcR = i_samples[1];

    // --------------------
    // Per-output sums
    // --------------------
    assign sumL = SUM_W'(scaleVol(i_volumes.ll, srcL)) + SUM_W'(scaleVol(i_volumes.rl, srcR));
    assign sumR = SUM_W'(scaleVol(i_volumes.lr, srcL)) + SUM_W'(scaleVol(i_volumes.rr, srcR));

    always_ff @(posedge i_clk) begin
        if (!i_nrst) begin
            o_mixL        <= '0;
            o_mixR        <= '0;
            o_sampleValid <= 1'b0;
        end else begin
            o_sampleValid <= i_tick;             // One cycle after the tick
            if (i_tick) begin
                o_mixL <= clampSample(sumL);
                o_mixR <= clampSample(sumR);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cdromTop.sv */
// --------------------
// CD-ROM host and audio top
// --------------------
`timescale 1ns/1ps
`default_nettype none

module cdromTop #(
    parameter int SAMPLE_PERIOD    = 768,
    parameter int PCM_DEPTH_LOG2   = 13,
    parameter int RESP_DEPTH_LOG2  = 4,
    parameter int PARAM_DEPTH_LOG2 = 4
) (
    input  logic                              i_clk,
    input  logic                              i_nrst,
    // Host bus
    input  cdromPkg::hostBus_t                i_host,
    output logic [cdromPkg::BYTE_W-1:0]       o_hostData,
    // Drive side bytes
    output logic [cdromPkg::BYTE_W-1:0]       o_paramData,
    output logic                              o_paramValid,
    input  logic                              i_paramTaken,
    input  logic [cdromPkg::BYTE_W-1:0]       i_respData,
    input  logic                              i_respWrite,
    // Drive side PCM
    input  logic [cdromPkg::NUM_CHANNELS-1:0] i_pcmWrite,
    input  cdromPkg::pcmFrame_t               i_pcmData,
    output logic [cdromPkg::NUM_CHANNELS-1:0] o_pcmFull,
    // Mixed audio out
    output cdromPkg::sample_t                 o_mixL,
    output cdromPkg::sample_t                 o_mixR,
    output logic                              o_sampleValid
);

    import cdromPkg::*;

    logic       tick;
    volumeSet_t workVolumes;
    pcmFrame_t  chanSamples;    // Heads after underflow substitution

    cdHostRegs #(
        .PARAM_DEPTH_LOG2 (PARAM_DEPTH_LOG2),
        .RESP_DEPTH_LOG2  (RESP_DEPTH_LOG2)
    ) hostRegs (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_host        (i_host),
        .o_hostData    (o_hostData),
        .o_paramData   (o_paramData),
        .o_paramValid  (o_paramValid),
        .i_paramTaken  (i_paramTaken),
        .i_respData    (i_respData),
        .i_respWrite   (i_respWrite),
        .o_workVolumes (workVolumes)
    );

    cdSamplePacer #(.SAMPLE_PERIOD(SAMPLE_PERIOD)) pacer (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .o_tick (tick)
    );

    // --------------------
    // PCM channels
    // --------------------
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : gChannel
        cdPcmChannel #(.DEPTH_LOG2(PCM_DEPTH_LOG2)) channel (
            .i_clk    (i_clk),
            .i_nrst   (i_nrst),
            .i_tick   (tick),
            .i_write  (i_pcmWrite[ch]),
            .i_sample (i_pcmData[ch]),
            .o_sample (chanSamples[ch]),
            .o_full   (o_pcmFull[ch])
        );
    end

    cdVolumeMixer mixer (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_tick        (tick),
        .i_samples     (chanSamples),
        .i_volumes     (workVolumes),
        .o_mixL        (o_mixL),
        .o_mixR        (o_mixR),
        .o_sampleValid (o_sampleValid)
    );

endmodule

`default_nettype wire

/* tb/cdromModel.svh */
// --------------------
// CD-ROM reference model
// --------------------
`ifndef CDROM_MODEL_SVH
`define CDROM_MODEL_SVH

// --------------------
// Model state
// --------------------
logic [1:0] mIndex;
logic [7:0] mIntEn;
volumeSet_t mStaged;                   // Written by the host
volumeSet_t mWork;                     // Used by the mixer
logic [7:0] paramQ [$];
logic [7:0] respQ [$];
sample_t    pcmQ [NUM_CHANNELS][$];    // One queue per channel
int         pacerCnt;
logic       pacerTick;                 // Pop tick seen during the next cycle
logic       expValid;
sample_t    expMixL;
sample_t    expMixR;
logic       clampHiSeen;
logic       clampLoSeen;

// floor(vol * smp / 128) with an unsigned volume
function automatic int volScale(input logic [7:0] vol, input sample_t smp);
    int p;
    int q;
    p = int'(vol) * int'(smp);
    q = p / 128;                        // Rounds toward zero
    if (p < 0 && q * 128 != p) begin
        q = q - 1;                      // Step down to the floor
    end
    return q;
endfunction

function automatic sample_t satSample(input int v);
    if (v > 32767) return 16'sh7fff;
    if (v < -32768) return 16'sh8000;
    return sample_t'(v);
endfunction

// Host read value for the current address and index
function automatic logic [7:0] expectedRead(input hostAddr_e adr);
    logic [7:0] st;
    st = {2'b00, respQ.size() != 0, paramQ.size() != PARAM_DEPTH_TB,
          paramQ.size() == 0, 1'b0, mIndex};
    case (adr)
        ADDR_INDEX_STATUS: return st;
        ADDR_CMD_RESP:     return (respQ.size() != 0) ? respQ[0] : 8'h00;
        ADDR_CTRL:         return mIndex[0] ? 8'h00 : mIntEn;
        default:           return 8'h00;                // PARAM reads nothing
    endcase
endfunction

task automatic modelReset();
    mIndex      = '0;
    mIntEn      = '0;
    mStaged     = '0;
    mWork       = '0;
    paramQ.delete();
    respQ.delete();
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        pcmQ[ch].delete();
    end
    pacerCnt    = 0;
    pacerTick   = 1'b0;
    expValid    = 1'b0;
    expMixL     = '0;
    expMixR     = '0;
    clampHiSeen = 1'b0;
    clampLoSeen = 1'b0;
endtask

// One rising edge, all decisions on pre-edge state
task automatic modelEdge();
    logic    wr;
    logic    rd;
    logic    tickNow;
    logic    pushOk;
    logic    popOk;
    logic    clr;
    int      sumL;
    int      sumR;
    sample_t head [NUM_CHANNELS];

    wr      = i_host.cs && i_host.write;
    rd      = i_host.cs && !i_host.write;
    tickNow = pacerTick;

    // Mixer, heads and working volumes before the edge
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        head[ch] = (pcmQ[ch].size() != 0) ? pcmQ[ch][0] : '0;   // Empty plays zero
    end
    expValid = tickNow;
    if (tickNow) begin
        sumL = volScale(mWork.ll, head[0]) + volScale(mWork.rl, head[1]);
        sumR = volScale(mWork.lr, head[0]) + volScale(mWork.rr, head[1]);
        if (sumL > 32767 || sumR > 32767) clampHiSeen = 1'b1;
        if (sumL < -32768 || sumR < -32768) clampLoSeen = 1'b1;
        expMixL = satSample(sumL);
        expMixR = satSample(sumR);
    end

    // PCM queues, one pop per tick
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        pushOk = i_pcmWrite[ch] && (pcmQ[ch].size() < PCM_DEPTH_TB);
        popOk  = tickNow && (pcmQ[ch].size() != 0);
        if (popOk) void'(pcmQ[ch].pop_front());
        if (pushOk) pcmQ[ch].push_back(i_pcmData[ch]);
    end

    // Sample period counter
    pacerTick = (pacerCnt == SAMPLE_PERIOD_TB - 1);
    pacerCnt  = pacerTick ? 0 : pacerCnt + 1;

    // Response bytes
    pushOk = i_respWrite && (respQ.size() < RESP_DEPTH_TB);
    popOk  = rd && (i_host.adr == ADDR_CMD_RESP) && (respQ.size() != 0);
    if (popOk) void'(respQ.pop_front());
    if (pushOk) respQ.push_back(i_respData);

    // Parameter bytes, clear wins
    clr    = wr && (i_host.adr == ADDR_CTRL) && (mIndex == 2'd1) && i_host.data[6];
    pushOk = wr && (i_host.adr == ADDR_PARAM) && (mIndex == 2'd0)
             && (paramQ.size() < PARAM_DEPTH_TB);
    popOk  = i_paramTaken && (paramQ.size() != 0);
    if (clr) begin
        paramQ.delete();
    end else begin
        if (popOk) void'(paramQ.pop_front());
        if (pushOk) paramQ.push_back(i_host.data);
    end

    // Register map
    if (wr) begin
        case (i_host.adr)
            ADDR_INDEX_STATUS: mIndex = i_host.data[1:0];
            ADDR_CMD_RESP: begin
                if (mIndex == 2'd3) mStaged.rr = i_host.data;
            end
            ADDR_PARAM: begin
                if (mIndex == 2'd1) mIntEn = i_host.data;
                if (mIndex == 2'd2) mStaged.ll = i_host.data;
                if (mIndex == 2'd3) mStaged.rl = i_host.data;
            end
            ADDR_CTRL: begin
                if (mIndex == 2'd2) mStaged.lr = i_host.data;
                if (mIndex == 2'd3 && i_host.data[5]) mWork = mStaged;   // Apply
            end
        endcase
    end
endtask

`endif

/* tb/cdromTb.sv */
// --------------------
// CD-ROM testbench
// --------------------
`timescale 1ns/1ps
`default_nettype none

module cdromTb;

    import cdromPkg::*;

    localparam int CLK_PERIOD       = 8;
    localparam int SAMPLE_PERIOD_TB = 32;
    localparam int PCM_DEPTH_TB     = 8;     // 2**3
    localparam int PARAM_DEPTH_TB   = 16;
    localparam int RESP_DEPTH_TB    = 16;
    localparam int PARAM_LOOP       = 60;
    localparam int RESP_LOOP        = 70;
    localparam int PCM_BLOCKS       = 10;
    localparam int PCM_BLOCK_LEN    = 100;
    // Cycle budget per phase with some slack
    localparam int TOTAL_CYCLES = 4 + 40 + (2 * PARAM_LOOP + 16) + (2 * RESP_LOOP + 24)
                                + PCM_BLOCKS * (PCM_BLOCK_LEN + 12)
                                + (16 + 15 * SAMPLE_PERIOD_TB);

    logic                    i_clk;
    logic                    i_nrst;
    hostBus_t                i_host;
    logic [BYTE_W-1:0]       o_hostData;
    logic [BYTE_W-1:0]       o_paramData;
    logic                    o_paramValid;
    logic                    i_paramTaken;
    logic [BYTE_W-1:0]       i_respData;
    logic                    i_respWrite;
    logic [NUM_CHANNELS-1:0] i_pcmWrite;
    pcmFrame_t               i_pcmData;
    logic [NUM_CHANNELS-1:0] o_pcmFull;
    sample_t                 o_mixL;
    sample_t                 o_mixR;
    logic                    o_sampleValid;

    // Values for the next falling edge
    hostBus_t                nextHost;
    logic                    nextTaken;
    logic [BYTE_W-1:0]       nextRespData;
    logic                    nextRespWrite;
    logic [NUM_CHANNELS-1:0] nextPcmWrite;
    pcmFrame_t               nextPcmData;
    int                      cycleCount;
    int                      lastValidCycle;
    int                      validCount;

    cdromTop #(
        .SAMPLE_PERIOD  (SAMPLE_PERIOD_TB),
        .PCM_DEPTH_LOG2 (3)
    ) uut (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_host        (i_host),
        .o_hostData    (o_hostData),
        .o_paramData   (o_paramData),
        .o_paramValid  (o_paramValid),
        .i_paramTaken  (i_paramTaken),
        .i_respData    (i_respData),
        .i_respWrite   (i_respWrite),
        .i_pcmWrite    (i_pcmWrite),
        .i_pcmData     (i_pcmData),
        .o_pcmFull     (o_pcmFull),
        .o_mixL        (o_mixL),
        .o_mixR        (o_mixR),
        .o_sampleValid (o_sampleValid)
    );

    `include "cdromModel.svh"

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Model follows every rising edge
    always @(posedge i_clk) begin
        if (!i_nrst) modelReset();
        else         modelEdge();
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    // Watchdog at twice the cycle budget
    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        failRun("Timeout, the run did not finish within its cycle budget");
    end

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        assert (got === exp)
        else failRun($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic checkOutputs();
        logic [NUM_CHANNELS-1:0] expFull;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            expFull[ch] = (pcmQ[ch].size() == PCM_DEPTH_TB);
        end
        checkValue("o_hostData", o_hostData, expectedRead(i_host.adr));
        checkValue("o_paramValid", o_paramValid, paramQ.size() != 0);
        if (paramQ.size() != 0) checkValue("o_paramData", o_paramData, paramQ[0]);
        checkValue("o_pcmFull", o_pcmFull, expFull);
        checkValue("o_sampleValid", o_sampleValid, expValid);
        checkValue("o_mixL", o_mixL, expMixL);
        checkValue("o_mixR", o_mixR, expMixR);
        if (o_sampleValid) begin
            assert (lastValidCycle < 0 || cycleCount - lastValidCycle == SAMPLE_PERIOD_TB)
            else failRun("o_sampleValid pulses are not one sample period apart");
            lastValidCycle = cycleCount;
            validCount++;
        end
    endtask

    // Drive on the falling edge and check once settled
    task automatic advanceCycle();
        @(negedge i_clk);
        i_host       = nextHost;
        i_paramTaken = nextTaken;
        i_respData   = nextRespData;
        i_respWrite  = nextRespWrite;
        i_pcmWrite   = nextPcmWrite;
        i_pcmData    = nextPcmData;
        #1;
        cycleCount++;
        checkOutputs();
        nextHost      = '0;          // Idle unless set again
        nextTaken     = 1'b0;
        nextRespWrite = 1'b0;
        nextPcmWrite  = '0;
    endtask

    function automatic hostBus_t makeAccess(input logic wr, input hostAddr_e adr,
                                            input logic [7:0] data);
        hostBus_t acc;
        acc.cs    = 1'b1;
        acc.write = wr;
        acc.adr   = adr;
        acc.data  = data;
        return acc;
    endfunction

    task automatic hostWrite(input hostAddr_e adr, input logic [7:0] data);
        nextHost = makeAccess(1'b1, adr, data);
        advanceCycle();
    endtask

    task automatic hostRead(input hostAddr_e adr);
        nextHost = makeAccess(1'b0, adr, 8'h00);
        advanceCycle();
    endtask

    task automatic setIndex(input logic [1:0] idx);
        hostWrite(ADDR_INDEX_STATUS, {6'($urandom), idx});   // Upper bits ignored
    endtask

    // Ends at index 3
    task automatic stageVolumes(input logic [7:0] ll, input logic [7:0] lr,
                                input logic [7:0] rl, input logic [7:0] rr);
        setIndex(2'd2);
        hostWrite(ADDR_PARAM, ll);
        hostWrite(ADDR_CTRL, lr);
        setIndex(2'd3);
        hostWrite(ADDR_PARAM, rl);
        hostWrite(ADDR_CMD_RESP, rr);
    endtask

    initial begin
        logic [7:0] data;
        logic [7:0] intEn;
        int         writeRate;

        void'($urandom(32'h594af120));
        i_nrst        = 1'b0;
        i_host        = '0;
        i_paramTaken  = 1'b0;
        i_respData    = '0;
        i_respWrite   = 1'b0;
        i_pcmWrite    = '0;
        i_pcmData     = '0;
        nextHost      = '0;
        nextTaken     = 1'b0;
        nextRespData  = '0;
        nextRespWrite = 1'b0;
        nextPcmWrite  = '0;
        nextPcmData   = '0;
        cycleCount     = 0;
        lastValidCycle = -1;
        validCount     = 0;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;

        // --------------------
        // Reset and registers
        // --------------------
        hostRead(ADDR_INDEX_STATUS);
        checkValue("o_hostData", o_hostData, 16'h0018);
        for (int i = 0; i < 8; i++) begin
            data = 8'($urandom);
            hostWrite(ADDR_INDEX_STATUS, data);
            hostRead(ADDR_INDEX_STATUS);
            checkValue("o_hostData[1:0]", o_hostData[1:0], data[1:0]);
        end
        intEn = 8'($urandom);
        setIndex(2'd1);
        hostWrite(ADDR_PARAM, intEn);
        for (int i = 0; i < 4; i++) begin
            setIndex(2'(i));
            hostRead(ADDR_CTRL);
            checkValue("o_hostData", o_hostData, (i % 2 == 0) ? intEn : 8'h00);
            hostRead(ADDR_PARAM);
            checkValue("o_hostData", o_hostData, 16'h0000);
        end

        // --------------------
        // Parameter FIFO
        // --------------------
        setIndex(2'd0);
        for (int i = 0; i < 2 * PARAM_LOOP; i++) begin
            if ($urandom_range(3) < ((i < PARAM_LOOP) ? 3 : 2))    // Fill hard and then mix
                nextHost = makeAccess(1'b1, ADDR_PARAM, 8'($urandom));
            else
                nextHost = makeAccess(1'b0, ADDR_INDEX_STATUS, 8'h00);
            nextTaken = (i < PARAM_LOOP) ? ($urandom_range(7) == 0) : ($urandom_range(1) == 0);
            advanceCycle();
        end
        for (int i = 0; i < 6; i++) begin
            hostWrite(ADDR_PARAM, 8'($urandom));
        end
        setIndex(2'd1);
        hostWrite(ADDR_CTRL, 8'($urandom) & 8'hbf);              // Bit 6 clear keeps the bytes
        hostRead(ADDR_INDEX_STATUS);
        checkValue("o_paramValid", o_paramValid, 16'h0001);
        hostWrite(ADDR_CTRL, 8'($urandom) | 8'h40);              // Clear
        hostRead(ADDR_INDEX_STATUS);
        checkValue("o_paramValid", o_paramValid, 16'h0000);
        checkValue("o_hostData[4:3]", o_hostData[4:3], 16'h0003);

        // --------------------
        // Response FIFO
        // --------------------
        for (int i = 0; i < 2 * RESP_LOOP; i++) begin
            nextRespWrite = (i < RESP_LOOP) ? ($urandom_range(3) != 0) : ($urandom_range(3) == 0);
            nextRespData  = 8'($urandom);
            if ((i < RESP_LOOP) == ($urandom_range(3) == 0))
                nextHost = makeAccess(1'b0, ADDR_CMD_RESP, 8'h00);
            else
                nextHost = makeAccess(1'b0, ADDR_INDEX_STATUS, 8'h00);
            advanceCycle();
        end
        repeat (RESP_DEPTH_TB + 1) hostRead(ADDR_CMD_RESP);      // Drain to empty
        checkValue("o_hostData", o_hostData, 16'h0000);

        // --------------------
        // PCM and volumes
        // --------------------
        for (int b = 0; b < PCM_BLOCKS; b++) begin
            stageVolumes(8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom));
            hostWrite(ADDR_CTRL, 8'($urandom) & 8'hdf);          // No apply
            if (b % 2 == 0) hostWrite(ADDR_CTRL, 8'($urandom) | 8'h20);
            writeRate = (b < PCM_BLOCKS / 2) ? 5 : 47;            // Busy first and sparse later
            for (int i = 0; i < PCM_BLOCK_LEN; i++) begin
                for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                    nextPcmWrite[ch] = ($urandom_range(writeRate) == 0);
                    nextPcmData[ch]  = sample_t'($urandom);
                end
                advanceCycle();
            end
        end

        // Full-scale volumes into both clamp limits
        stageVolumes(8'hff, 8'hff, 8'hff, 8'hff);
        hostWrite(ADDR_CTRL, 8'h20);
        repeat ((PCM_DEPTH_TB + 2) * SAMPLE_PERIOD_TB) advanceCycle();
        for (int i = 0; i < 4; i++) begin
            nextPcmWrite   = 2'b11;
            nextPcmData[0] = (i < 2) ? 16'sh7fff : 16'sh8000;
            nextPcmData[1] = nextPcmData[0];
            advanceCycle();
        end
        repeat (5 * SAMPLE_PERIOD_TB) advanceCycle();

        if (clampHiSeen && clampLoSeen && validCount > 0) begin
            $display("sim passed");
            $finish;
        end else begin
            failRun("The mix never reached both clamp limits");
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+tb
logic/cdromPkg.sv
logic/syncFifo.sv
logic/cdHostRegs.sv
logic/cdSamplePacer.sv
logic/cdPcmChannel.sv
logic/cdVolumeMixer.sv
logic/cdromTop.sv
tb/cdromTb.sv

/* run.sh */
#!/bin/bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal -f files.f --top-module cdromTb \
    -Mdir obj_dir -o cdromSim
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/cdromSim 2>&1 | tee "$LOG"
simStatus=${PIPESTATUS[0]}
if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
